//--- Makefile
SIM = obj_dir/Vmuldiv_tb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb -f muldiv.f
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing --assert --top-module muldiv_tb -f muldiv.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- muldiv.f
source/muldiv_pkg.sv
source/muldiv_dispatch.sv
source/int_mul_iterative.sv
source/int_div_iterative.sv
source/muldiv_resp_merge.sv
source/muldiv_top.sv
tests/muldiv_tb.sv

//--- source/int_div_iterative.sv
// iterative 32/32 restoring divider, one request at a time
// divide by zero gives all-ones quotient and the dividend as remainder
// signed remainder follows the dividend sign

module int_div_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  logic                          req_signed,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic                          req_rdy,
  output logic                          resp_val,
  output logic [muldiv_pkg::XLEN-1:0]   resp_quotient,
  output logic [muldiv_pkg::XLEN-1:0]   resp_remainder,
  input  logic                          resp_rdy
);
  import muldiv_pkg::*;

  localparam int CNT_W = $clog2(XLEN) + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;

  // datapath registers
  // quo starts as the dividend and fills with quotient bits from the right
  logic [XLEN-1:0]  quo;
  logic [XLEN-1:0]  rem;
  logic [XLEN-1:0]  dvsr;
  logic             q_neg;
  logic             r_neg;

  logic [XLEN-1:0]  a_mag;
  logic [XLEN-1:0]  b_mag;
  logic [XLEN:0]    shifted;
  logic [XLEN:0]    diff;
  logic             req_go;
  logic             resp_go;
  logic             load;
  logic             step;
  logic             fix;

  // --------------------
  // control
  // --------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  assign load = req_go;
  assign step = (state == st_calc) && (cnt != '0);
  assign fix  = (state == st_calc) && (cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            cnt   <= CNT_W'(XLEN);
          end
        end
        st_calc: begin
          if (cnt == '0) begin
            state <= st_done;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  assign a_mag = (req_signed && req_a[XLEN-1]) ? -req_a : req_a;
  assign b_mag = (req_signed && req_b[XLEN-1]) ? -req_b : req_b;

  // bring in the next dividend bit, then trial subtract
  // one extra bit so a borrow shows up in diff msb
  assign shifted = {rem, quo[XLEN-1]};
  assign diff    = shifted - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (load) begin
      quo   <= a_mag;
      rem   <= '0;
      dvsr  <= b_mag;
      // zero divisor keeps the quotient positive so all ones survive
      q_neg <= req_signed && (req_a[XLEN-1] ^ req_b[XLEN-1]) && (req_b != '0);
      r_neg <= req_signed && req_a[XLEN-1];
    end else if (step) begin
      if (!diff[XLEN]) begin
        rem <= diff[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        // restore, keep the shifted remainder
        rem <= shifted[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end else if (fix) begin
      if (q_neg) begin
        quo <= -quo;
      end
      if (r_neg) begin
        rem <= -rem;
      end
    end
  end

  assign resp_quotient  = quo;
  assign resp_remainder = rem;

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("divider dropped resp_val before transfer");

endmodule

//--- source/int_mul_iterative.sv
// iterative 32x32 shift-add multiplier, one request at a time
// 32 iteration cycles plus one sign fix cycle, full 64-bit product

module int_mul_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  logic                          req_signed,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic                          req_rdy,
  output logic                          resp_val,
  output logic [2*muldiv_pkg::XLEN-1:0] resp_product,
  input  logic                          resp_rdy
);
  import muldiv_pkg::*;

  localparam int CNT_W = $clog2(XLEN) + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e            state;
  logic [CNT_W-1:0]  cnt;

  // datapath registers
  logic [2*XLEN-1:0] mcand;
  logic [XLEN-1:0]   mplier;
  logic [2*XLEN-1:0] prod;
  logic              neg;

  // magnitudes and control strobes
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic              req_go;
  logic              resp_go;
  logic              load;
  logic              step;
  logic              fix;

  // --------------------
  // control
  // --------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  // calc runs while cnt counts down, the cycle at zero applies the sign
  assign load = req_go;
  assign step = (state == st_calc) && (cnt != '0);
  assign fix  = (state == st_calc) && (cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            cnt   <= CNT_W'(XLEN);
          end
        end
        st_calc: begin
          if (cnt == '0) begin
            state <= st_done;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  // unsigned requests pass straight through
  assign a_mag = (req_signed && req_a[XLEN-1]) ? -req_a : req_a;
  assign b_mag = (req_signed && req_b[XLEN-1]) ? -req_b : req_b;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      prod   <= '0;
      // product sign only matters for signed requests
      neg    <= req_signed && (req_a[XLEN-1] ^ req_b[XLEN-1]);
    end else if (step) begin
      // add shifted multiplicand when the multiplier lsb is set
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (fix) begin
      if (neg) begin
        prod <= -prod;
      end
    end
  end

  // product held in prod for the whole done state
  assign resp_product = prod;

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("multiplier dropped resp_val before transfer");

  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_product))
    else $error("multiplier product changed while stalled");

endmodule

//--- source/muldiv_dispatch.sv
// input side of the unit, holds one request and steers it to an engine
// ORDER_DEPTH must be a power of two, 2 or more

module muldiv_dispatch #(
  parameter int ORDER_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  muldiv_pkg::muldiv_op_e        req_op,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic                          req_rdy,
  output logic                          mul_req_val,
  output logic                          div_req_val,
  output logic [muldiv_pkg::XLEN-1:0]   opnd_a,
  output logic [muldiv_pkg::XLEN-1:0]   opnd_b,
  output logic                          opnd_signed,
  input  logic                          mul_req_rdy,
  input  logic                          div_req_rdy,
  output logic                          order_val,
  output muldiv_pkg::engine_sel_e       order_head,
  input  logic                          order_pop
);
  import muldiv_pkg::*;

  localparam int PTR_W = $clog2(ORDER_DEPTH);

  // holding register
  logic            started;
  logic            hold_val;
  muldiv_op_e      hold_op;
  logic [XLEN-1:0] hold_a;
  logic [XLEN-1:0] hold_b;

  // decoded request
  engine_sel_e     target;
  logic            is_signed;

  // order queue
  engine_sel_e     q_mem [ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   q_count;
  logic            q_full;
  logic            push;
  logic            accept;

  // --------------------
  // request holding register
  // --------------------

  // ready only once out of reset and while the holder is empty
  assign req_rdy = started && !hold_val;
  assign accept  = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      started  <= 1'b0;
      hold_val <= 1'b0;
    end else begin
      started <= 1'b1;
      if (accept) begin
        hold_val <= 1'b1;
      end else if (push) begin
        hold_val <= 1'b0;
      end
    end
  end

  // payload has no reset, only qualified by hold_val
  always_ff @(posedge clk) begin
    if (accept) begin
      hold_op <= req_op;
      hold_a  <= req_a;
      hold_b  <= req_b;
    end
  end

  // --------------------
  // opcode decode
  // --------------------

  always_comb begin
    target    = eng_mul;
    is_signed = 1'b0;
    case (hold_op)
      op_mul:  begin
        target    = eng_mul;
        is_signed = 1'b1;
      end
      op_mulu: begin
        target    = eng_mul;
        is_signed = 1'b0;
      end
      op_div:  begin
        target    = eng_div;
        is_signed = 1'b1;
      end
      op_divu: begin
        target    = eng_div;
        is_signed = 1'b0;
      end
      default: ;
    endcase
  end

  // both engines see the same operands, only one valid is raised
  assign opnd_a      = hold_a;
  assign opnd_b      = hold_b;
  assign opnd_signed = is_signed;

  // offer only while the queue can record the engine
  assign mul_req_val = hold_val && !q_full && (target == eng_mul);
  assign div_req_val = hold_val && !q_full && (target == eng_div);

  assign push = (mul_req_val && mul_req_rdy) || (div_req_val && div_req_rdy);

  // --------------------
  // order queue
  // --------------------

  assign q_full     = (q_count == (PTR_W+1)'(ORDER_DEPTH));
  assign order_val  = (q_count != '0);
  assign order_head = q_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (order_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // count moves only when push and pop differ
      if (push && !order_pop) begin
        q_count <= q_count + 1'b1;
      end else if (!push && order_pop) begin
        q_count <= q_count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= target;
    end
  end

  // a push into a full queue would carry the count past the depth
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    q_count <= (PTR_W+1)'(ORDER_DEPTH))
    else $error("dispatch pushed into a full order queue");

  // merge pops only what dispatch recorded earlier
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    order_pop |-> order_val)
    else $error("merge popped an empty order queue");

endmodule

//--- source/muldiv_pkg.sv
// shared widths and encodings for the multiply/divide unit
// operand width is fixed here, results are always twice as wide

package muldiv_pkg;

  // --------------------
  // widths
  // --------------------

  // operand width, results are 2*XLEN
  localparam int XLEN = 32;

  // --------------------
  // encodings
  // --------------------

  // request opcode as seen on req_op
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // engine that owns a request, kept in the order queue
  typedef enum logic {
    eng_mul = 1'b0,
    eng_div = 1'b1
  } engine_sel_e;

endpackage

//--- source/muldiv_resp_merge.sv
// output side, takes engine results strictly in queue order
// one response register, refilled in the same cycle it drains

module muldiv_resp_merge (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          mul_resp_val,
  input  logic [2*muldiv_pkg::XLEN-1:0] mul_resp_product,
  output logic                          mul_resp_rdy,
  input  logic                          div_resp_val,
  input  logic [muldiv_pkg::XLEN-1:0]   div_resp_quotient,
  input  logic [muldiv_pkg::XLEN-1:0]   div_resp_remainder,
  output logic                          div_resp_rdy,
  input  logic                          order_val,
  input  muldiv_pkg::engine_sel_e       order_head,
  output logic                          order_pop,
  output logic                          resp_val,
  output logic [2*muldiv_pkg::XLEN-1:0] resp_result,
  input  logic                          resp_rdy
);
  import muldiv_pkg::*;

  logic take_ok;
  logic mul_take;
  logic div_take;

  // register is free when empty or handing its value out this cycle
  assign take_ok = !resp_val || resp_rdy;

  // only the engine at the queue head is offered ready
  assign mul_resp_rdy = take_ok && order_val && (order_head == eng_mul);
  assign div_resp_rdy = take_ok && order_val && (order_head == eng_div);

  assign mul_take  = mul_resp_val && mul_resp_rdy;
  assign div_take  = div_resp_val && div_resp_rdy;
  assign order_pop = mul_take || div_take;

  // --------------------
  // response register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (order_pop) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // divider packs remainder over quotient
  always_ff @(posedge clk) begin
    if (mul_take) begin
      resp_result <= mul_resp_product;
    end else if (div_take) begin
      resp_result <= {div_resp_remainder, div_resp_quotient};
    end
  end

  // the engine named at the head stays there until its result is taken
  a_head_only: assert property (@(posedge clk) disable iff (reset)
    order_val && !order_pop |=> order_val && $stable(order_head))
    else $error("order queue head changed before its result was taken");

endmodule

//--- source/muldiv_top.sv
// multiply/divide unit, results come back in request order
// idle latency is 35 cycles from request to response

module muldiv_top #(
  parameter int ORDER_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  output logic                          req_rdy,
  input  muldiv_pkg::muldiv_op_e        req_op,
  input  logic [muldiv_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_pkg::XLEN-1:0]   req_b,
  output logic                          resp_val,
  input  logic                          resp_rdy,
  output logic [2*muldiv_pkg::XLEN-1:0] resp_result
);
  import muldiv_pkg::*;

  // --------------------
  // dispatch to engines
  // --------------------
  logic              mul_req_val;
  logic              mul_req_rdy;
  logic              div_req_val;
  logic              div_req_rdy;
  logic [XLEN-1:0]   opnd_a;
  logic [XLEN-1:0]   opnd_b;
  logic              opnd_signed;

  // engines to merge
  logic              mul_resp_val;
  logic              mul_resp_rdy;
  logic [2*XLEN-1:0] mul_resp_product;
  logic              div_resp_val;
  logic              div_resp_rdy;
  logic [XLEN-1:0]   div_resp_quotient;
  logic [XLEN-1:0]   div_resp_remainder;

  // order queue
  logic              order_val;
  engine_sel_e       order_head;
  logic              order_pop;

  muldiv_dispatch #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) u_dispatch (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .mul_req_val (mul_req_val),
    .div_req_val (div_req_val),
    .opnd_a      (opnd_a),
    .opnd_b      (opnd_b),
    .opnd_signed (opnd_signed),
    .mul_req_rdy (mul_req_rdy),
    .div_req_rdy (div_req_rdy),
    .order_val   (order_val),
    .order_head  (order_head),
    .order_pop   (order_pop)
  );

  int_mul_iterative u_mul (
    .clk          (clk),
    .reset        (reset),
    .req_val      (mul_req_val),
    .req_signed   (opnd_signed),
    .req_a        (opnd_a),
    .req_b        (opnd_b),
    .req_rdy      (mul_req_rdy),
    .resp_val     (mul_resp_val),
    .resp_product (mul_resp_product),
    .resp_rdy     (mul_resp_rdy)
  );

  int_div_iterative u_div (
    .clk            (clk),
    .reset          (reset),
    .req_val        (div_req_val),
    .req_signed     (opnd_signed),
    .req_a          (opnd_a),
    .req_b          (opnd_b),
    .req_rdy        (div_req_rdy),
    .resp_val       (div_resp_val),
    .resp_quotient  (div_resp_quotient),
    .resp_remainder (div_resp_remainder),
    .resp_rdy       (div_resp_rdy)
  );

  muldiv_resp_merge u_merge (
    .clk                (clk),
    .reset              (reset),
    .mul_resp_val       (mul_resp_val),
    .mul_resp_product   (mul_resp_product),
    .mul_resp_rdy       (mul_resp_rdy),
    .div_resp_val       (div_resp_val),
    .div_resp_quotient  (div_resp_quotient),
    .div_resp_remainder (div_resp_remainder),
    .div_resp_rdy       (div_resp_rdy),
    .order_val          (order_val),
    .order_head         (order_head),
    .order_pop          (order_pop),
    .resp_val           (resp_val),
    .resp_result        (resp_result),
    .resp_rdy           (resp_rdy)
  );

endmodule

//--- tests/muldiv_tb.sv
// random and corner stimulus for muldiv_top, checked against a behavioral model
// inputs change 1 unit after the rising edge, handshakes are sampled on the falling edge

module muldiv_tb;
  import muldiv_pkg::*;

  localparam int ACCEPT_LIMIT = 1000;
  localparam int RESP_LIMIT   = 100;
  localparam int DRAIN_LIMIT  = 4000;
  localparam int IDLE_LATENCY = 35;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  muldiv_op_e        req_op;
  logic [XLEN-1:0]   req_a;
  logic [XLEN-1:0]   req_b;
  logic              resp_val;
  logic              resp_rdy;
  logic [2*XLEN-1:0] resp_result;

  // scoreboard and bookkeeping
  logic [2*XLEN-1:0] exp_q [$];
  logic [31:0]       rng_state;
  logic              stall_mode;
  logic              req_taken;
  logic              hold_pending;
  logic [2*XLEN-1:0] held_result;
  int                cycle_cnt;
  int                accept_cycle;
  int                resp_cycle;
  int                received;

  muldiv_top #(
    .ORDER_DEPTH (4)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // period of 4
  always #2 clk = ~clk;

  // --------------------
  // random numbers
  // --------------------

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // corners show up often, shifted values give small divisors
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] r;
    logic [31:0] v;
    r = rand32();
    v = rand32();
    case (r[2:0])
      3'd0: v = 32'h0000_0000;
      3'd1: v = 32'h0000_0001;
      3'd2: v = 32'hffff_ffff;
      3'd3: v = 32'h8000_0000;
      3'd4: v = v >> r[8:4];
      default: ;
    endcase
    return v;
  endfunction

  // --------------------
  // reference model
  // --------------------

  function automatic logic [2*XLEN-1:0] model_result(input muldiv_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic [XLEN-1:0]          q;
    logic [XLEN-1:0]          r;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    q  = '1;
    r  = a;
    case (op)
      op_mul:  return sa * sb;
      op_mulu: return {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
      op_divu: begin
        if (b != '0) begin
          q = a / b;
          r = a % b;
        end
      end
      default: begin
        // signed overflow case has a fixed answer
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = 32'h8000_0000;
          r = '0;
        end else if (b != '0) begin
          q = $signed(a) / $signed(b);
          r = $signed(a) % $signed(b);
        end
      end
    endcase
    return {r, q};
  endfunction

  // --------------------
  // checks
  // --------------------

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_result(input string name, input logic [2*XLEN-1:0] got,
                                input logic [2*XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // --------------------
  // one clock cycle
  // --------------------

  // sample handshakes before the edge, then step to the next drive point
  task automatic tick();
    logic [2*XLEN-1:0] exp_val;
    logic [31:0]       rdy_draw;
    @(negedge clk);
    // a stalled response must not move
    if (hold_pending) begin
      compare_bit("resp_val", resp_val, 1'b1);
      compare_result("resp_result (stalled)", resp_result, held_result);
    end
    hold_pending = resp_val && !resp_rdy;
    held_result  = resp_result;
    if (req_val && req_rdy) begin
      exp_q.push_back(model_result(req_op, req_a, req_b));
      req_taken    = 1'b1;
      accept_cycle = cycle_cnt + 1;
    end
    if (resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("a response arrived with no request outstanding at time %0t", $time);
        abort_run();
      end else begin
        exp_val = exp_q.pop_front();
        compare_result("resp_result", resp_result, exp_val);
        resp_cycle = cycle_cnt;
        received++;
      end
    end
    @(posedge clk);
    #1;
    cycle_cnt++;
    rdy_draw = rand32();
    // roughly one stall cycle in four
    resp_rdy = stall_mode ? (rdy_draw[1:0] != 2'b00) : 1'b1;
  endtask

  task automatic send_request(input muldiv_op_e op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
    int waited;
    req_val   = 1'b1;
    req_op    = op;
    req_a     = a;
    req_b     = b;
    req_taken = 1'b0;
    waited    = 0;
    while (!req_taken) begin
      if (waited >= ACCEPT_LIMIT) begin
        $display("timeout, request not accepted within %0d cycles", ACCEPT_LIMIT);
        abort_run();
      end else begin
        tick();
        waited++;
      end
    end
    req_val = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= DRAIN_LIMIT) begin
        $display("timeout, %0d responses still missing", exp_q.size());
        abort_run();
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  // single request into an idle unit, response latency is fixed
  task automatic check_idle_latency(input muldiv_op_e op, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    int start;
    int waited;
    start  = received;
    waited = 0;
    send_request(op, a, b);
    while (received == start) begin
      if (waited >= RESP_LIMIT) begin
        $display("timeout, no response within %0d cycles of an idle request", RESP_LIMIT);
        abort_run();
      end else begin
        tick();
        waited++;
      end
    end
    compare_count("response latency", resp_cycle - accept_cycle, IDLE_LATENCY);
  endtask

  task automatic run_random(input int count, input logic stalls);
    logic [31:0] r;
    logic [31:0] gap_draw;
    stall_mode = stalls;
    for (int i = 0; i < count; i++) begin
      r = rand32();
      send_request(muldiv_op_e'(r[1:0]), pick_operand(), pick_operand());
      gap_draw = rand32();
      // occasional idle gaps between requests
      if (stalls && gap_draw[3:2] == 2'b00) begin
        repeat (gap_draw[6:4]) tick();
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_op       = op_mul;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b1;
    rng_state    = 32'h1852_f4cb;
    stall_mode   = 1'b0;
    req_taken    = 1'b0;
    hold_pending = 1'b0;
    held_result  = '0;
    cycle_cnt    = 0;
    accept_cycle = 0;
    resp_cycle   = 0;
    received     = 0;

    // nothing offered or returned during reset
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      compare_bit("req_rdy", req_rdy, 1'b0);
      compare_bit("resp_val", resp_val, 1'b0);
    end
    reset = 1'b0;
    tick();
    compare_bit("req_rdy", req_rdy, 1'b1);

    check_idle_latency(op_mul, 32'hffff_fffd, 32'h0000_0007);
    check_idle_latency(op_divu, 32'h0001_0000, 32'h0000_0003);

    // corners, back to back
    send_request(op_div, 32'h8000_0000, 32'hffff_ffff);
    send_request(op_div, 32'hffff_fff9, 32'h0000_0000);
    send_request(op_divu, 32'h1234_5678, 32'h0000_0000);
    send_request(op_div, 32'hffff_fff9, 32'h0000_0002);
    send_request(op_div, 32'h0000_0007, 32'hffff_fffe);
    send_request(op_mul, 32'h8000_0000, 32'h8000_0000);
    send_request(op_mulu, 32'hffff_ffff, 32'hffff_ffff);
    send_request(op_mul, 32'hffff_ffff, 32'h0000_0001);
    drain_responses();

    // mixed stream with both engines busy, then with consumer stalls
    run_random(200, 1'b0);
    drain_responses();
    run_random(300, 1'b1);
    stall_mode = 1'b0;
    drain_responses();

    // a duplicated result would show up as an extra response here
    repeat (2 * IDLE_LATENCY) tick();
    compare_bit("resp_val", resp_val, 1'b0);
    compare_bit("req_rdy", req_rdy, 1'b1);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
